// File: merge_pkg.sv
`default_nettype none

package merge_pkg;

    localparam int COEF_ONE = 16;
    localparam int CHAN_MAX = 31;

    // encoding is also the bit index into a layer mask
    typedef enum logic [2:0] {
        layer_bg0 = 3'd0,
        layer_bg1 = 3'd1,
        layer_bg2 = 3'd2,
        layer_bg3 = 3'd3,
        layer_obj = 3'd4,
        layer_bd  = 3'd5
    } layer_e;

    typedef logic [5:0] layer_mask_t;

    typedef enum logic [1:0] {
        effect_none     = 2'd0,
        effect_alpha    = 2'd1,
        effect_brighten = 2'd2,
        effect_darken   = 2'd3
    } effect_e;

    typedef struct packed {
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } rgb15_t;

    typedef struct packed {
        logic   transparent;
        rgb15_t color;
    } bg_pixel_t;

    typedef struct packed {
        logic [1:0] prio;
        logic       transparent;
        rgb15_t     color;
    } obj_pixel_t;

    typedef struct packed {
        logic [4:0]      layer_ena;
        logic [3:0][1:0] bg_prio;
        effect_e         mode;
        layer_mask_t     first_target;
        layer_mask_t     second_target;
        logic [4:0]      eva;
        logic [4:0]      evb;
        logic [4:0]      bldy;
    } merge_config_t;

    typedef struct packed {
        logic            valid;
        logic [7:0]      x;
        logic [7:0]      y;
        bg_pixel_t [3:0] bg;
        obj_pixel_t      obj;
        rgb15_t          backdrop;
    } pixel_stage_t;

    typedef struct packed {
        pixel_stage_t stage;
        layer_e       top;
        logic         first_hit;
        rgb15_t       first_color;
        layer_mask_t  second;
    } prio_result_t;

    // raw effect channels, index 2 blue down to 0 red
    typedef logic [8:0] chan9_t;
    typedef logic signed [8:0] schan9_t;

    typedef struct packed {
        logic          valid;
        logic [7:0]    x;
        logic [7:0]    y;
        rgb15_t        top_color;
        logic          apply;
        effect_e       mode;
        chan9_t [2:0]  alpha_raw;
        chan9_t [2:0]  bright_raw;
        schan9_t [2:0] dark_raw;
    } blend_result_t;

    function automatic rgb15_t layer_color(input pixel_stage_t p, input layer_e l);
        case (l)
            layer_bg0: return p.bg[0].color;
            layer_bg1: return p.bg[1].color;
            layer_bg2: return p.bg[2].color;
            layer_bg3: return p.bg[3].color;
            layer_obj: return p.obj.color;
            default:   return p.backdrop;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: merge_config_latch.sv
`timescale 1ns/1ps
`default_nettype none

module merge_config_latch import merge_pkg::*; (
    input  wire logic          fclk,
    input  wire logic          reset,
    input  wire logic          hblank,
    input  wire merge_config_t cfg_in,
    output merge_config_t      cfg
);

    merge_config_t cfg_clamped;

    // anything above full weight acts as full weight
    function automatic logic [4:0] clamp_coef(input logic [4:0] coef);
        if (coef > COEF_ONE) begin
            return 5'(COEF_ONE);
        end
        return coef;
    endfunction

    always_comb begin
        cfg_clamped      = cfg_in;
        cfg_clamped.eva  = clamp_coef(cfg_in.eva);
        cfg_clamped.evb  = clamp_coef(cfg_in.evb);
        cfg_clamped.bldy = clamp_coef(cfg_in.bldy);
    end

    // ########################################
    // line config, taken only during hblank
    // ########################################

    always_ff @(posedge fclk) begin
        if (reset) begin
            cfg <= '0;
        end else if (hblank) begin
            cfg <= cfg_clamped;
        end
    end

endmodule

`default_nettype wire

// File: layer_priority.sv
`timescale 1ns/1ps
`default_nettype none

module layer_priority import merge_pkg::*; (
    input  wire logic          fclk,
    input  wire logic          reset,
    input  wire merge_config_t cfg,
    input  wire pixel_stage_t  pix,
    output prio_result_t       res
);

    pixel_stage_t s1_pix;
    layer_mask_t  s1_vis;

    pixel_stage_t s2_pix;
    layer_mask_t  s2_vis;
    layer_e       s2_top;

    logic         first_hit;
    layer_mask_t  first_mask;
    layer_mask_t  second_vis;
    layer_e       second_top;
    layer_mask_t  second_mask;

    // lowest bg prio wins, lower index on ties, sprite wins when <= all visible bgs
    function automatic layer_e pick_top(
        input layer_mask_t     vis,
        input logic [3:0][1:0] bg_prio,
        input logic [1:0]      obj_prio
    );
        logic       bg_found;
        logic [1:0] best_prio;
        layer_e     best;
        bg_found  = 1'b0;
        best_prio = 2'd3;
        best      = layer_bd;
        for (int i = 0; i < 4; i++) begin
            if (vis[i] && (!bg_found || bg_prio[i] < best_prio)) begin
                bg_found  = 1'b1;
                best_prio = bg_prio[i];
                best      = layer_e'(i);
            end
        end
        if (vis[layer_obj] && (!bg_found || obj_prio <= best_prio)) begin
            best = layer_obj;
        end
        return best;
    endfunction

    // ########################################
    // stage 1: visibility
    // ########################################

    always_ff @(posedge fclk) begin
        if (reset) begin
            s1_pix.valid <= 1'b0;
        end else begin
            s1_pix <= pix;
            for (int i = 0; i < 4; i++) begin
                s1_vis[i] <= cfg.layer_ena[i] & ~pix.bg[i].transparent;
            end
            s1_vis[layer_obj] <= cfg.layer_ena[layer_obj] & ~pix.obj.transparent;
            // backdrop never drops out
            s1_vis[layer_bd]  <= 1'b1;
        end
    end

    // ########################################
    // stage 2: top layer
    // ########################################

    always_ff @(posedge fclk) begin
        if (reset) begin
            s2_pix.valid <= 1'b0;
        end else begin
            s2_pix <= s1_pix;
            s2_vis <= s1_vis;
            s2_top <= pick_top(s1_vis, cfg.bg_prio, s1_pix.obj.prio);
        end
    end

    // ########################################
    // stage 3: effect targets
    // ########################################

    always_comb begin
        first_hit   = cfg.first_target[s2_top];
        first_mask  = first_hit ? (layer_mask_t'(1) << s2_top) : '0;
        second_vis  = s2_vis & ~first_mask;
        second_top  = pick_top(second_vis, cfg.bg_prio, s2_pix.obj.prio);
        // one-hot candidate, zero if not a second target
        second_mask = (layer_mask_t'(1) << second_top) & cfg.second_target;
    end

    always_ff @(posedge fclk) begin
        if (reset) begin
            res.stage.valid <= 1'b0;
        end else begin
            res.stage       <= s2_pix;
            res.top         <= s2_top;
            res.first_hit   <= first_hit;
            res.first_color <= layer_color(s2_pix, s2_top);
            res.second      <= second_mask;
        end
    end

endmodule

`default_nettype wire

// File: color_blend.sv
`timescale 1ns/1ps
`default_nettype none

module color_blend import merge_pkg::*; (
    input  wire logic          fclk,
    input  wire logic          reset,
    input  wire merge_config_t cfg,
    input  wire prio_result_t  res,
    output blend_result_t      blend
);

    rgb15_t          second_color;
    logic            second_hit;
    logic [2:0][4:0] first_ch;
    logic [2:0][4:0] second_ch;
    blend_result_t   blend_next;

    always_comb begin
        second_color = '0;
        for (int i = 0; i < 6; i++) begin
            if (res.second[i]) begin
                second_color = layer_color(res.stage, layer_e'(i));
            end
        end
        second_hit = |res.second;
        first_ch   = res.first_color;
        second_ch  = second_color;
    end

    // ########################################
    // effect arithmetic, all three in parallel
    // ########################################

    always_comb begin
        blend_next.valid     = res.stage.valid;
        blend_next.x         = res.stage.x;
        blend_next.y         = res.stage.y;
        blend_next.top_color = layer_color(res.stage, res.top);
        blend_next.mode      = cfg.mode;
        for (int c = 0; c < 3; c++) begin
            blend_next.alpha_raw[c] = 9'((first_ch[c] * cfg.eva
                                          + second_ch[c] * cfg.evb) / COEF_ONE);
            blend_next.bright_raw[c] = 9'(first_ch[c]
                                          + (CHAN_MAX - first_ch[c]) * cfg.bldy / COEF_ONE);
            blend_next.dark_raw[c] = 9'(first_ch[c] - first_ch[c] * cfg.bldy / COEF_ONE);
        end
        case (cfg.mode)
            // alpha needs a layer underneath to mix with
            effect_alpha:    blend_next.apply = res.first_hit & second_hit;
            effect_brighten: blend_next.apply = res.first_hit;
            effect_darken:   blend_next.apply = res.first_hit;
            default:         blend_next.apply = 1'b0;
        endcase
    end

    always_ff @(posedge fclk) begin
        if (reset) begin
            blend.valid <= 1'b0;
        end else begin
            blend <= blend_next;
        end
    end

endmodule

`default_nettype wire

// File: pixel_output.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_output import merge_pkg::*; (
    input  wire logic          fclk,
    input  wire logic          reset,
    input  wire blend_result_t blend,
    output logic               pixel_valid,
    output logic [7:0]         pixel_x,
    output logic [7:0]         pixel_y,
    output rgb15_t             pixel_color
);

    logic [2:0][4:0] top_ch;
    logic [2:0][4:0] effect_ch;
    rgb15_t          out_color;

    function automatic logic [4:0] sat_high(input chan9_t v);
        if (v > CHAN_MAX) begin
            return 5'(CHAN_MAX);
        end
        return v[4:0];
    endfunction

    function automatic logic [4:0] sat_low(input schan9_t v);
        if (v < 0) begin
            return 5'd0;
        end
        return v[4:0];
    endfunction

    // per channel saturation for the selected effect
    always_comb begin
        top_ch = blend.top_color;
        for (int c = 0; c < 3; c++) begin
            case (blend.mode)
                effect_alpha:    effect_ch[c] = sat_high(blend.alpha_raw[c]);
                effect_brighten: effect_ch[c] = sat_high(blend.bright_raw[c]);
                effect_darken:   effect_ch[c] = sat_low(blend.dark_raw[c]);
                default:         effect_ch[c] = top_ch[c];
            endcase
        end
        out_color = blend.apply ? rgb15_t'(effect_ch) : blend.top_color;
    end

    // ########################################
    // output register
    // ########################################

    always_ff @(posedge fclk) begin
        if (reset) begin
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= blend.valid;
            if (blend.valid) begin
                pixel_x     <= blend.x;
                pixel_y     <= blend.y;
                pixel_color <= out_color;
            end
        end
    end

endmodule

`default_nettype wire

// File: gba_layer_merge.sv
`timescale 1ns/1ps
`default_nettype none

module gba_layer_merge import merge_pkg::*; (
    input  wire logic            fclk,
    input  wire logic            reset,
    input  wire logic            hblank,
    input  wire merge_config_t   cfg_in,
    input  wire logic            pixel_in_valid,
    input  wire logic [7:0]      x,
    input  wire logic [7:0]      y,
    input  wire bg_pixel_t [3:0] bg,
    input  wire obj_pixel_t      obj,
    input  wire rgb15_t          backdrop,
    output logic                 pixel_valid,
    output logic [7:0]           pixel_x,
    output logic [7:0]           pixel_y,
    output rgb15_t               pixel_color
);

    merge_config_t cfg;
    pixel_stage_t  pix_in;
    prio_result_t  res;
    blend_result_t blend;

    // backdrop rides along with the layer pixels
    assign pix_in.valid    = pixel_in_valid;
    assign pix_in.x        = x;
    assign pix_in.y        = y;
    assign pix_in.bg       = bg;
    assign pix_in.obj      = obj;
    assign pix_in.backdrop = backdrop;

    merge_config_latch u_config (
        .fclk   (fclk),
        .reset  (reset),
        .hblank (hblank),
        .cfg_in (cfg_in),
        .cfg    (cfg)
    );

    layer_priority u_priority (
        .fclk  (fclk),
        .reset (reset),
        .cfg   (cfg),
        .pix   (pix_in),
        .res   (res)
    );

    color_blend u_blend (
        .fclk  (fclk),
        .reset (reset),
        .cfg   (cfg),
        .res   (res),
        .blend (blend)
    );

    pixel_output u_output (
        .fclk        (fclk),
        .reset       (reset),
        .blend       (blend),
        .pixel_valid (pixel_valid),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_color (pixel_color)
    );

endmodule

`default_nettype wire

// File: tb_gba_layer_merge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gba_layer_merge import merge_pkg::*; ();

    localparam int LATENCY = 5;
    // about 1200 pixels plus drain and hblank per line, roughly 2100 cycles
    localparam int TIMEOUT_CYCLES = 4000;

    typedef struct packed {
        rgb15_t      color;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [31:0] issue;
    } expect_t;

    logic            fclk;
    logic            reset;
    logic            hblank;
    merge_config_t   cfg_in;
    logic            pixel_in_valid;
    logic [7:0]      x;
    logic [7:0]      y;
    bg_pixel_t [3:0] bg;
    obj_pixel_t      obj;
    rgb15_t          backdrop;
    logic            pixel_valid;
    logic [7:0]      pixel_x;
    logic [7:0]      pixel_y;
    rgb15_t          pixel_color;

    merge_config_t   model_cfg = '0;
    expect_t         exp_q[$];
    expect_t         head;
    logic [31:0]     cycle = '0;
    logic [7:0]      px = '0;
    logic [7:0]      line_y = '0;

    gba_layer_merge dut_i (
        .fclk           (fclk),
        .reset          (reset),
        .hblank         (hblank),
        .cfg_in         (cfg_in),
        .pixel_in_valid (pixel_in_valid),
        .x              (x),
        .y              (y),
        .bg             (bg),
        .obj            (obj),
        .backdrop       (backdrop),
        .pixel_valid    (pixel_valid),
        .pixel_x        (pixel_x),
        .pixel_y        (pixel_y),
        .pixel_color    (pixel_color)
    );

    initial begin
        fclk = 1'b0;
        forever #10 fclk = ~fclk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, name, got, want);
        abort_run();
    endtask

    // ########################################
    // reference model
    // ########################################

    // scan priorities upward, sprite first at each level
    function automatic int ref_top(input logic [5:0] vis, input logic [3:0][1:0] prio,
                                   input logic [1:0] obj_prio);
        for (int p = 0; p < 4; p++) begin
            if (vis[4] && obj_prio == p) begin
                return 4;
            end
            for (int i = 0; i < 4; i++) begin
                if (vis[i] && prio[i] == p) begin
                    return i;
                end
            end
        end
        return 5;
    endfunction

    function automatic logic [4:0] ref_chan(input merge_config_t c, input int a, input int b);
        int v;
        case (c.mode)
            effect_alpha:    v = (a * int'(c.eva) + b * int'(c.evb)) / COEF_ONE;
            effect_brighten: v = a + (CHAN_MAX - a) * int'(c.bldy) / COEF_ONE;
            default:         v = a - a * int'(c.bldy) / COEF_ONE;
        endcase
        if (v > CHAN_MAX) begin
            v = CHAN_MAX;
        end
        if (v < 0) begin
            v = 0;
        end
        return 5'(v);
    endfunction

    function automatic rgb15_t ref_pixel(input merge_config_t c, input bg_pixel_t [3:0] b,
                                         input obj_pixel_t o, input rgb15_t bd);
        logic [5:0] vis;
        logic [5:0] vis2;
        rgb15_t     cols [6];
        int         top;
        int         second;
        logic       first_hit;
        logic       apply;
        rgb15_t     r;
        for (int i = 0; i < 4; i++) begin
            vis[i]  = c.layer_ena[i] && !b[i].transparent;
            cols[i] = b[i].color;
        end
        vis[4]  = c.layer_ena[4] && !o.transparent;
        cols[4] = o.color;
        vis[5]  = 1'b1;
        cols[5] = bd;
        top       = ref_top(vis, c.bg_prio, o.prio);
        first_hit = c.first_target[top];
        vis2      = vis;
        if (first_hit) begin
            vis2[top] = 1'b0;
        end
        second = ref_top(vis2, c.bg_prio, o.prio);
        case (c.mode)
            effect_alpha:    apply = first_hit && c.second_target[second];
            effect_brighten: apply = first_hit;
            effect_darken:   apply = first_hit;
            default:         apply = 1'b0;
        endcase
        if (!apply) begin
            return cols[top];
        end
        r.red   = ref_chan(c, cols[top].red, cols[second].red);
        r.green = ref_chan(c, cols[top].green, cols[second].green);
        r.blue  = ref_chan(c, cols[top].blue, cols[second].blue);
        return r;
    endfunction

    function automatic merge_config_t clamp_coefs(input merge_config_t c);
        c.eva  = (c.eva > COEF_ONE) ? 5'(COEF_ONE) : c.eva;
        c.evb  = (c.evb > COEF_ONE) ? 5'(COEF_ONE) : c.evb;
        c.bldy = (c.bldy > COEF_ONE) ? 5'(COEF_ONE) : c.bldy;
        return c;
    endfunction

    function automatic merge_config_t random_config(input effect_e mode);
        merge_config_t c;
        c.layer_ena     = 5'($urandom);
        c.bg_prio       = 8'($urandom);
        c.mode          = mode;
        c.first_target  = 6'($urandom);
        c.second_target = 6'($urandom);
        c.eva           = 5'($urandom);
        c.evb           = 5'($urandom);
        c.bldy          = 5'($urandom);
        return c;
    endfunction

    // ########################################
    // stimulus tasks
    // ########################################

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge fclk);
            pixel_in_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        @(posedge fclk);
        pixel_in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge fclk);
        end
    endtask

    // new line: config goes in during hblank with the pipeline empty
    task automatic load_config(input merge_config_t c);
        drain();
        @(posedge fclk);
        cfg_in <= c;
        hblank <= 1'b1;
        @(posedge fclk);
        hblank <= 1'b0;
        model_cfg = clamp_coefs(c);
        line_y    = line_y + 8'd1;
        px        = '0;
    endtask

    task automatic send_random_pixel(input int transp_pct);
        bg_pixel_t [3:0] b;
        obj_pixel_t      o;
        rgb15_t          bd;
        expect_t         e;
        for (int i = 0; i < 4; i++) begin
            b[i].transparent = ($urandom_range(0, 99) < transp_pct);
            b[i].color       = 15'($urandom);
        end
        o.prio        = 2'($urandom);
        o.transparent = ($urandom_range(0, 99) < transp_pct);
        o.color       = 15'($urandom);
        bd            = 15'($urandom);
        if ($urandom_range(0, 7) == 0) begin
            drive_idle(1);
        end
        @(posedge fclk);
        pixel_in_valid <= 1'b1;
        x              <= px;
        y              <= line_y;
        bg             <= b;
        obj            <= o;
        backdrop       <= bd;
        e.color = ref_pixel(model_cfg, b, o, bd);
        e.x     = px;
        e.y     = line_y;
        // index of this edge, the counter updates after it
        e.issue = cycle + 1;
        exp_q.push_back(e);
        px = px + 8'd1;
    endtask

    // ########################################
    // checking and timeout
    // ########################################

    always @(posedge fclk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            report_failure("run did not finish within the cycle limit");
        end
    end

    always @(negedge fclk) begin
        if (pixel_valid) begin
            assert (exp_q.size() != 0)
                else report_failure("pixel_valid high with no pixel in flight");
            head = exp_q.pop_front();
            assert (pixel_x == head.x)
                else report_mismatch("pixel_x", pixel_x, head.x);
            assert (pixel_y == head.y)
                else report_mismatch("pixel_y", pixel_y, head.y);
            assert (pixel_color == head.color)
                else report_mismatch("pixel_color", pixel_color, head.color);
            assert (cycle - head.issue == LATENCY)
                else report_failure($sformatf("pixel x %0d y %0d took %0d cycles, expected %0d",
                                              head.x, head.y, cycle - head.issue, LATENCY));
        end
    end

    // ########################################
    // test sequence
    // ########################################

    initial begin
        merge_config_t c;
        void'($urandom(27));
        reset          = 1'b1;
        hblank         = 1'b0;
        cfg_in         = '0;
        pixel_in_valid = 1'b0;
        x              = '0;
        y              = '0;
        bg             = '0;
        obj            = '0;
        backdrop       = '0;
        repeat (8) @(posedge fclk);
        reset <= 1'b0;
        drive_idle(4);

        // zero config after reset, backdrop only
        repeat (16) send_random_pixel(50);

        // priority, mode none
        for (int n = 0; n < 20; n++) begin
            load_config(random_config(effect_none));
            repeat (24) send_random_pixel(40);
        end

        // every enable combination, lots of transparency
        for (int m = 0; m < 32; m++) begin
            c = random_config(effect_none);
            c.layer_ena = 5'(m);
            load_config(c);
            repeat (8) send_random_pixel(60);
        end

        // alpha blend
        for (int n = 0; n < 10; n++) begin
            load_config(random_config(effect_alpha));
            repeat (24) send_random_pixel(30);
        end

        // brighten and darken, first lines push bldy past 16
        for (int n = 0; n < 8; n++) begin
            c = random_config((n % 2 == 0) ? effect_brighten : effect_darken);
            if (n < 2) begin
                c.bldy         = 5'd31;
                c.first_target = '1;
            end
            load_config(c);
            repeat (24) send_random_pixel(30);
        end

        // cfg_in change outside hblank stays invisible
        load_config(random_config(effect_alpha));
        c = random_config(effect_darken);
        @(posedge fclk);
        cfg_in <= c;
        repeat (16) send_random_pixel(30);
        load_config(c);
        repeat (16) send_random_pixel(30);

        // last pixel has a fixed number of edges to come out
        drive_idle(LATENCY + 2);
        assert (exp_q.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            report_failure("expected pixels left over at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: gba_merge.f
merge_pkg.sv
merge_config_latch.sv
layer_priority.sv
color_blend.sv
pixel_output.sv
gba_layer_merge.sv
tb_gba_layer_merge.sv
